//--- build.f
src/qam_pkg.sv
src/reg_bus_if.sv
src/spi_cmd_port.sv
src/reg_arbiter.sv
src/register_bank.sv
src/qam64_mapper.sv
src/modulator_64qam_top.sv
testbench/tb_modulator_64qam.sv

//--- Makefile
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f build.f \
		--top-module tb_modulator_64qam --Mdir $(OBJ_DIR) -o sim_tb

run: compile
	./$(OBJ_DIR)/sim_tb | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/qam_tests.txt
# op and operands: W addr data | R addr expect (hex) | C n | G | Y i q (signed levels)
# C holds back credits and counts the waiting symbols, G hands credits back
C 0
R 00 0000
W 05 a5c3
W 7f 1234
R 05 a5c3
R 7f 1234
R 06 0000
W 10 ff04
W 11 3ecd
W 12 001f
W 13 8016
W 14 0032
W 15 5a7b
W 16 0029
W 17 c0e0
W 00 8008
C 4
G
Y -7 7
Y -5 5
Y -3 3
Y -1 1
Y 1 -1
Y 3 -3
Y 5 -5
Y 7 -7
R 01 0008
R 00 0000
W 00 8005
R 12 001f
W 40 beef
R 40 beef
Y -7 7
Y -5 5
Y -3 3
Y -1 1
Y 1 -1
R 01 0005
R 00 0000

//--- testbench/tb_modulator_64qam.sv
`timescale 1ns/10ps
`default_nettype none

module tb_modulator_64qam;

   localparam string TEST_FILE    = "testbench/qam_tests.txt";
   localparam int    QUIET_CYCLES = 40;  // stream counts as stopped after this
   localparam int    LOG_DEPTH    = 64;

   logic                SCLK;
   logic                rst_n;
   logic                MOSI;
   logic                CSN;
   logic                sym_credit;
   logic                MISO;
   logic                MISO_enable;
   logic                sym_valid;
   qam_pkg::qam_level_t sym_i;
   qam_pkg::qam_level_t sym_q;

   // symbol log, written by the monitor and read in order by Y lines
   qam_pkg::qam_level_t log_i [LOG_DEPTH];
   qam_pkg::qam_level_t log_q [LOG_DEPTH];
   int seen_cnt     = 0;
   int consumed_cnt = 0;
   int returned_cnt = 0;        // credits handed back so far
   bit credits_on   = 1'b1;
   int seed         = 9088;

   logic [15:0] miso_word = '0;  // newest 16 MISO bits
   int          miso_bits = 0;

   int cycle_cnt    = 0;
   int cycle_limit  = 500;
   int tests_run    = 0;
   int tests_failed = 0;
   int check_errors = 0;
   bit op_failed;

   modulator_64qam_top u_dut (
      .SCLK        (SCLK),
      .rst_n       (rst_n),
      .MOSI        (MOSI),
      .CSN         (CSN),
      .sym_credit  (sym_credit),
      .MISO        (MISO),
      .MISO_enable (MISO_enable),
      .sym_valid   (sym_valid),
      .sym_i       (sym_i),
      .sym_q       (sym_q)
   );

   always #20 SCLK = ~SCLK;  // 40 ns period

   always @(posedge SCLK) begin
      if (sym_valid) begin
         log_i[seen_cnt % LOG_DEPTH] <= sym_i;
         log_q[seen_cnt % LOG_DEPTH] <= sym_q;
         seen_cnt <= seen_cnt + 1;
      end
   end

   // master side sampling of the read window
   always @(posedge SCLK) begin
      if (MISO_enable) begin
         miso_word <= {miso_word[14:0], MISO};
         miso_bits <= miso_bits + 1;
      end
   end

   always @(posedge SCLK) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
         $display("Errors found");
         $finish;
      end
   end

   // one credit per seen symbol, random lag of 1 to 4 cycles
   initial begin : credit_return
      int lag;
      sym_credit = 1'b0;
      forever begin
         @(posedge SCLK);
         if (credits_on && returned_cnt < seen_cnt) begin
            lag = 1 + ($unsigned($random(seed)) % 4);
            repeat (lag - 1) @(posedge SCLK);
            #5 sym_credit = 1'b1;
            @(posedge SCLK);
            #5 sym_credit = 1'b0;
            returned_cnt++;
         end
      end
   end

   task automatic check_hex(input string sig, input logic [15:0] exp, input logic [15:0] got);
      assert (got === exp) else begin
         $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, sig, exp, got);
         op_failed = 1'b1;
         check_errors++;
      end
   endtask

   task automatic check_int(input string sig, input int exp, input int got);
      assert (got == exp) else begin
         $display("CHECK FAILED at %0t ns: %s expected %0d got %0d", $time, sig, exp, got);
         op_failed = 1'b1;
         check_errors++;
      end
   endtask

   task automatic finish_test(input string what);
      tests_run++;
      if (op_failed) begin
         tests_failed++;
      end
      $display("test %0d  %-12s %s", tests_run, what, op_failed ? "FAIL" : "ok");
   endtask

   // rw, addr, data msb first, then 7 idle bits
   task automatic send_frame(input logic rw, input logic [7:0] addr, input logic [15:0] data);
      logic [31:0] frame;
      frame = {rw, addr, data, 7'b0};
      @(posedge SCLK);
      #5;
      CSN  = 1'b0;
      MOSI = frame[31];
      for (int k = 1; k < 32; k++) begin
         @(posedge SCLK);
         #5;
         MOSI = frame[31-k];
      end
      @(posedge SCLK);
      #5;
      CSN  = 1'b1;      // port is back in idle here
      MOSI = 1'b0;
      @(posedge SCLK);  // gap between frames
      #5;
   endtask

   task automatic read_reg(input logic [7:0] addr, input logic [15:0] exp);
      int bits_before;
      bits_before = miso_bits;
      send_frame(1'b0, addr, 16'h0000);
      check_int("MISO_enable cycles", 16, miso_bits - bits_before);
      check_hex($sformatf("MISO reg %h", addr), exp, miso_word);
   endtask

   // stop credits and wait for the stream to stall
   task automatic count_held_symbols(input int n);
      int quiet;
      int last;
      credits_on = 1'b0;
      quiet      = 0;
      last       = seen_cnt;
      while (quiet < QUIET_CYCLES) begin
         @(posedge SCLK);
         #5;
         if (seen_cnt != last) begin
            quiet = 0;
            last  = seen_cnt;
         end else begin
            quiet++;
         end
      end
      check_int("sym_valid pulses", n, seen_cnt - consumed_cnt);
   endtask

   task automatic expect_symbol(input int exp_i, input int exp_q);
      while (seen_cnt == consumed_cnt) begin  // watchdog bounds this
         @(posedge SCLK);
         #5;
      end
      check_int("sym_i", exp_i, int'(log_i[consumed_cnt % LOG_DEPTH]));
      check_int("sym_q", exp_q, int'(log_q[consumed_cnt % LOG_DEPTH]));
      consumed_cnt++;
   endtask

   task automatic run_tests(input int fd);
      logic [63:0]      op;
      logic [7:0]       addr;
      logic [15:0]      data;
      int               a;
      int               b;
      int               rc;
      logic [8*128-1:0] rest;
      while ($fscanf(fd, "%s", op) == 1) begin
         op_failed = 1'b0;
         if (op == "#") begin
            rc = $fgets(rest, fd);                   // column notes
         end else if (op == "W") begin
            rc = $fscanf(fd, "%h %h", addr, data);
            send_frame(1'b1, addr, data);
            finish_test($sformatf("W %h %h", addr, data));
         end else if (op == "R") begin
            rc = $fscanf(fd, "%h %h", addr, data);
            read_reg(addr, data);
            finish_test($sformatf("R %h %h", addr, data));
         end else if (op == "C") begin
            rc = $fscanf(fd, "%d", a);
            count_held_symbols(a);
            finish_test($sformatf("C %0d", a));
         end else if (op == "G") begin
            credits_on = 1'b1;                       // owed credits flow back
            finish_test("G");
         end else if (op == "Y") begin
            rc = $fscanf(fd, "%d %d", a, b);
            expect_symbol(a, b);
            finish_test($sformatf("Y %0d %0d", a, b));
         end else begin
            $display("unknown opcode %0s in the test file", op);
            op_failed = 1'b1;
            check_errors++;
            finish_test("bad line");
         end
      end
   endtask

   initial begin : main
      int               fd;
      int               rc;
      int               n_lines;
      logic [8*128-1:0] text;
      SCLK    = 1'b0;
      rst_n   = 1'b0;
      MOSI    = 1'b0;
      CSN     = 1'b1;
      n_lines = 0;

      // run length bound from the size of the test file
      fd = $fopen(TEST_FILE, "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            rc = $fgets(text, fd);
            if (rc > 0) begin
               n_lines++;
            end
         end
         $fclose(fd);
      end
      cycle_limit = n_lines * 64 + 500;

      repeat (2) @(posedge SCLK);
      #5 rst_n = 1'b1;

      op_failed = 1'b0;
      check_hex("MISO_enable", 16'h0000, {15'b0, MISO_enable});
      check_hex("sym_valid", 16'h0000, {15'b0, sym_valid});
      finish_test("reset state");

      fd = $fopen(TEST_FILE, "r");
      if (fd == 0) begin
         $display("could not open the test file %s", TEST_FILE);
         check_errors++;
      end else begin
         run_tests(fd);
         $fclose(fd);
      end

      // nothing extra may have come out
      assert (seen_cnt == consumed_cnt) else begin
         $display("%0d symbols arrived that no Y line expected", seen_cnt - consumed_cnt);
         check_errors++;
      end

      $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, check_errors);
      if (check_errors == 0 && tests_failed == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src/modulator_64qam_top.sv
`timescale 1ns/10ps
`default_nettype none

module modulator_64qam_top (
   input  wire                 SCLK,
   input  wire                 rst_n,
   input  wire                 MOSI,
   input  wire                 CSN,
   input  wire                 sym_credit,
   output logic                MISO,
   output logic                MISO_enable,
   output logic                sym_valid,
   output qam_pkg::qam_level_t sym_i,
   output qam_pkg::qam_level_t sym_q
);

   // one bus per client plus the bank side
   reg_bus_if spi_bus  ();
   reg_bus_if map_bus  ();
   reg_bus_if bank_bus ();

   spi_cmd_port u_spi (
      .SCLK        (SCLK),
      .rst_n       (rst_n),
      .MOSI        (MOSI),
      .CSN         (CSN),
      .MISO        (MISO),
      .MISO_enable (MISO_enable),
      .bus         (spi_bus)
   );

   qam64_mapper u_mapper (
      .SCLK       (SCLK),
      .rst_n      (rst_n),
      .sym_credit (sym_credit),
      .sym_valid  (sym_valid),
      .sym_i      (sym_i),
      .sym_q      (sym_q),
      .bus        (map_bus)
   );

   // spi first, mapper takes the gaps
   reg_arbiter u_arb (
      .SCLK  (SCLK),
      .rst_n (rst_n),
      .spi   (spi_bus),
      .map   (map_bus),
      .bank  (bank_bus)
   );

   register_bank u_bank (
      .SCLK  (SCLK),
      .rst_n (rst_n),
      .bus   (bank_bus)
   );

endmodule

`default_nettype wire

//--- src/qam64_mapper.sv
`timescale 1ns/10ps
`default_nettype none

module qam64_mapper (
   input  wire                 SCLK,
   input  wire                 rst_n,
   input  wire                 sym_credit,
   output logic                sym_valid,
   output qam_pkg::qam_level_t sym_i,
   output qam_pkg::qam_level_t sym_q,
   reg_bus_if.client           bus
);

   qam_pkg::map_state_t              state;
   qam_pkg::credit_t                 credits;
   logic [qam_pkg::CTRL_CNT_W-1:0]   sym_cnt;   // N from REG_CTRL
   logic [qam_pkg::CTRL_CNT_W-1:0]   sym_idx;   // next word in the block
   logic [5:0]                       word;      // low six bits of fetched word
   logic                             rd_wait;   // read granted, data next cycle
   logic                             emit;

   // gray code to amplitude, same table for I and Q
   function automatic qam_pkg::qam_level_t gray_level(input logic [2:0] code);
      case (code)
         3'b000:  return -4'sd7;
         3'b001:  return -4'sd5;
         3'b011:  return -4'sd3;
         3'b010:  return -4'sd1;
         3'b110:  return 4'sd1;
         3'b111:  return 4'sd3;
         3'b101:  return 4'sd5;
         default: return 4'sd7;   // 100
      endcase
   endfunction

   assign emit = (state == qam_pkg::MAP_EMIT) && (credits != '0);

   // credit return and emit may coincide
   always_ff @(posedge SCLK or negedge rst_n) begin
      if (!rst_n) begin
         credits <= qam_pkg::credit_t'(qam_pkg::QAM_CREDITS);
      end else begin
         case ({sym_credit, emit})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   always_ff @(posedge SCLK or negedge rst_n) begin
      if (!rst_n) begin
         state     <= qam_pkg::MAP_POLL;
         sym_cnt   <= '0;
         sym_idx   <= '0;
         word      <= '0;
         rd_wait   <= 1'b0;
         bus.req   <= 1'b0;
         bus.we    <= 1'b0;
         bus.addr  <= '0;
         bus.wdata <= '0;
      end else begin
         if (bus.req && bus.gnt) begin
            bus.req <= 1'b0;
            rd_wait <= !bus.we;                    // writes need no return
         end
         if (bus.rvalid) begin
            rd_wait <= 1'b0;
         end

         case (state)
            qam_pkg::MAP_POLL: begin
               if (!bus.req && !rd_wait) begin     // keep reading REG_CTRL
                  bus.req  <= 1'b1;
                  bus.we   <= 1'b0;
                  bus.addr <= qam_pkg::REG_CTRL;
               end
               if (bus.rvalid && bus.rdata[qam_pkg::CTRL_START]) begin
                  sym_cnt <= bus.rdata[qam_pkg::CTRL_CNT_W-1:0];
                  sym_idx <= '0;
                  state   <= qam_pkg::MAP_FETCH;
               end
            end

            qam_pkg::MAP_FETCH: begin
               if (sym_idx == sym_cnt) begin
                  state <= qam_pkg::MAP_STATUS;    // block done
               end else if (!bus.req && !rd_wait) begin
                  bus.req  <= 1'b1;
                  bus.we   <= 1'b0;
                  bus.addr <= qam_pkg::REG_DATA_BASE + qam_pkg::reg_addr_t'(sym_idx);
               end
               if (bus.rvalid) begin
                  word  <= bus.rdata[5:0];
                  state <= qam_pkg::MAP_EMIT;
               end
            end

            qam_pkg::MAP_EMIT: begin
               if (emit) begin                     // stalls here with no credit
                  sym_idx <= sym_idx + 1'b1;
                  state   <= qam_pkg::MAP_FETCH;
               end
            end

            qam_pkg::MAP_STATUS: begin
               if (!bus.req) begin
                  bus.req   <= 1'b1;
                  bus.we    <= 1'b1;
                  bus.addr  <= qam_pkg::REG_STATUS;
                  bus.wdata <= qam_pkg::reg_data_t'(sym_cnt);
               end else if (bus.gnt) begin
                  state <= qam_pkg::MAP_CLEAR;
               end
            end

            qam_pkg::MAP_CLEAR: begin
               if (!bus.req) begin
                  bus.req   <= 1'b1;
                  bus.we    <= 1'b1;
                  bus.addr  <= qam_pkg::REG_CTRL;
                  bus.wdata <= '0;                 // drops start and count
               end else if (bus.gnt) begin
                  state <= qam_pkg::MAP_POLL;
               end
            end

            default: begin
               state <= qam_pkg::MAP_POLL;
            end
         endcase
      end
   end

   always_ff @(posedge SCLK or negedge rst_n) begin
      if (!rst_n) begin
         sym_valid <= 1'b0;
      end else begin
         sym_valid <= emit;                        // one cycle per symbol
      end
   end

   // bits 5:3 select I and bits 2:0 select Q
   always_ff @(posedge SCLK) begin
      if (emit) begin
         sym_i <= gray_level(word[5:3]);
         sym_q <= gray_level(word[2:0]);
      end
   end

   // an underflow would wrap and also land above the limit
   a_credit_range : assert property (
      @(posedge SCLK) disable iff (!rst_n)
      credits <= qam_pkg::credit_t'(qam_pkg::QAM_CREDITS)
   ) else $error("credit counter out of range");

endmodule

`default_nettype wire

//--- src/register_bank.sv
`timescale 1ns/10ps
`default_nettype none

module register_bank (
   input  wire     SCLK,
   input  wire     rst_n,
   reg_bus_if.bank bus
);

   qam_pkg::reg_data_t mem [qam_pkg::REG_WORDS];

   // single port with no wait states
   assign bus.gnt = bus.req;

   always_ff @(posedge SCLK or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < qam_pkg::REG_WORDS; i++) begin
            mem[i] <= '0;                         // whole map starts cleared
         end
         bus.rvalid <= 1'b0;
      end else begin
         if (bus.gnt && bus.we) begin
            mem[bus.addr] <= bus.wdata;           // lands on the grant edge
         end
         bus.rvalid <= bus.gnt && !bus.we;
      end
   end

   // read word registered, valid alongside rvalid
   always_ff @(posedge SCLK) begin
      if (bus.gnt && !bus.we) begin
         bus.rdata <= mem[bus.addr];
      end
   end

endmodule

`default_nettype wire

//--- src/reg_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module reg_arbiter (
   input  wire       SCLK,
   input  wire       rst_n,
   reg_bus_if.bank   spi,
   reg_bus_if.bank   map,
   reg_bus_if.client bank
);

   logic rd_owner_spi;  // who gets the next rvalid

   // spi has fixed priority
   assign bank.req   = spi.req | map.req;
   assign bank.we    = spi.req ? spi.we    : map.we;
   assign bank.addr  = spi.req ? spi.addr  : map.addr;
   assign bank.wdata = spi.req ? spi.wdata : map.wdata;

   assign spi.gnt = spi.req & bank.gnt;
   assign map.gnt = map.req & ~spi.req & bank.gnt;   // only when spi is quiet

   // read data goes to both clients and only rvalid is steered
   assign spi.rdata  = bank.rdata;
   assign map.rdata  = bank.rdata;
   assign spi.rvalid = bank.rvalid & rd_owner_spi;
   assign map.rvalid = bank.rvalid & ~rd_owner_spi;

   always_ff @(posedge SCLK or negedge rst_n) begin
      if (!rst_n) begin
         rd_owner_spi <= 1'b0;
      end else if (bank.req && bank.gnt && !bank.we) begin
         rd_owner_spi <= spi.req;                    // winner of this read
      end
   end

   // every request cycle grants exactly one client
   a_one_grant : assert property (
      @(posedge SCLK) disable iff (!rst_n)
      (spi.req || map.req) |-> (spi.gnt ^ map.gnt)
   ) else $error("grant missing or given to both clients");

   a_spi_rvalid : assert property (
      @(posedge SCLK) disable iff (!rst_n)
      (bank.gnt && !bank.we && spi.req) |=> (spi.rvalid && !map.rvalid)
   ) else $error("spi read data not returned to spi");

   a_map_rvalid : assert property (
      @(posedge SCLK) disable iff (!rst_n)
      (bank.gnt && !bank.we && !spi.req) |=> (map.rvalid && !spi.rvalid)
   ) else $error("mapper read data not returned to mapper");

endmodule

`default_nettype wire

//--- src/spi_cmd_port.sv
`timescale 1ns/10ps
`default_nettype none

module spi_cmd_port (
   input  wire       SCLK,
   input  wire       rst_n,
   input  wire       MOSI,
   input  wire       CSN,
   output logic      MISO,
   output logic      MISO_enable,
   reg_bus_if.client bus
);

   qam_pkg::spi_state_t state;
   qam_pkg::frame_cnt_t bit_cnt;      // frame cycles left
   logic                rw_bit;       // latched frame bit 0
   qam_pkg::reg_data_t  shift_in;     // MOSI history, newest bit in lsb
   qam_pkg::reg_data_t  miso_buf;     // read word, msb goes out first
   logic                miso_pos;     // rising edge copy of MISO
   logic                miso_en_pos;  // rising edge copy of MISO_enable

   // MOSI shifted on every rising edge, frame position comes from bit_cnt
   always_ff @(posedge SCLK) begin
      shift_in <= {shift_in[14:0], MOSI};
   end

   always_ff @(posedge SCLK or negedge rst_n) begin
      if (!rst_n) begin
         state       <= qam_pkg::SPI_IDLE;
         bit_cnt     <= '0;
         rw_bit      <= 1'b0;
         miso_pos    <= 1'b0;
         miso_en_pos <= 1'b0;
         bus.req     <= 1'b0;
         bus.we      <= 1'b0;
         bus.addr    <= '0;
         bus.wdata   <= '0;
      end else begin
         // spi always wins arbitration so this drops after one cycle
         if (bus.req && bus.gnt) begin
            bus.req <= 1'b0;
         end
         if (state != qam_pkg::SPI_IDLE) begin
            bit_cnt <= bit_cnt - 1'b1;
         end

         case (state)
            qam_pkg::SPI_IDLE: begin
               if (!CSN) begin                      // frame bit 0 sampled now
                  state   <= qam_pkg::SPI_RW;
                  bit_cnt <= qam_pkg::FRAME_CNT_LOAD;
               end
            end

            qam_pkg::SPI_RW: begin
               rw_bit <= shift_in[0];
               state  <= qam_pkg::SPI_ADDR;
            end

            qam_pkg::SPI_ADDR: begin
               if (bit_cnt == qam_pkg::FRAME_CNT_ADDR) begin
                  bus.addr <= shift_in[7:0];        // bits 1..8, msb first
                  if (rw_bit) begin
                     state <= qam_pkg::SPI_WRITE;
                  end else begin
                     state   <= qam_pkg::SPI_READ;
                     bus.req <= 1'b1;               // read right after address
                     bus.we  <= 1'b0;
                  end
               end
            end

            qam_pkg::SPI_READ: begin
               if (bus.rvalid) begin                // window opens here
                  miso_pos    <= bus.rdata[15];
                  miso_buf    <= {bus.rdata[14:0], 1'b0};
                  miso_en_pos <= 1'b1;
               end else if (miso_en_pos) begin
                  miso_pos <= miso_buf[15];
                  miso_buf <= {miso_buf[14:0], 1'b0};
               end
               if (bit_cnt == qam_pkg::FRAME_CNT_MISO_OFF) begin
                  miso_en_pos <= 1'b0;              // 16 cycles done
                  miso_pos    <= 1'b0;
               end
               if (bit_cnt == qam_pkg::FRAME_CNT_END) begin
                  state <= qam_pkg::SPI_IDLE;
               end
            end

            qam_pkg::SPI_WRITE: begin
               if (bit_cnt == qam_pkg::FRAME_CNT_WRITE) begin
                  bus.req   <= 1'b1;                // last data bit is in
                  bus.we    <= 1'b1;
                  bus.wdata <= shift_in;
               end
               if (bit_cnt == qam_pkg::FRAME_CNT_END) begin
                  state <= qam_pkg::SPI_IDLE;
               end
            end

            default: begin
               state <= qam_pkg::SPI_IDLE;
            end
         endcase
      end
   end

   // miso path retimed so the master samples on rising edges
   always_ff @(negedge SCLK or negedge rst_n) begin
      if (!rst_n) begin
         MISO        <= 1'b0;
         MISO_enable <= 1'b0;
      end else begin
         MISO        <= miso_pos;
         MISO_enable <= miso_en_pos;
      end
   end

   // fixed window timing relies on the arbiter never stalling this port
   a_req_one_cycle : assert property (
      @(posedge SCLK) disable iff (!rst_n) $rose(bus.req) |=> !bus.req
   ) else $error("spi request not granted in its first cycle");

endmodule

`default_nettype wire

//--- src/reg_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface reg_bus_if;

   // client side
   logic               req;    // held until gnt
   logic               we;     // 1 write, 0 read
   qam_pkg::reg_addr_t addr;
   qam_pkg::reg_data_t wdata;

   // bank side
   logic               gnt;    // same cycle as req
   qam_pkg::reg_data_t rdata;
   logic               rvalid; // one cycle after a read grant

   modport client (
      output req, we, addr, wdata,
      input  gnt, rdata, rvalid
   );

   modport bank (
      input  req, we, addr, wdata,
      output gnt, rdata, rvalid
   );

endinterface

`default_nettype wire

//--- src/qam_pkg.sv
`default_nettype none

package qam_pkg;

   // register bank geometry
   localparam int REG_WORDS = 256;
   typedef logic [7:0]  reg_addr_t;
   typedef logic [15:0] reg_data_t;

   // register map
   localparam reg_addr_t REG_CTRL      = 8'h00;   // start bit and symbol count
   localparam reg_addr_t REG_STATUS    = 8'h01;   // symbols sent in last block
   localparam reg_addr_t REG_DATA_BASE = 8'h10;   // first data word
   localparam int CTRL_START = 15;
   localparam int CTRL_CNT_W = 5;                 // count field is bits 4:0

   // spi frame, 1 rw + 8 addr + 16 data + 7 trailing
   localparam int FRAME_BITS      = 32;
   localparam int FRAME_ADDR_BITS = 8;
   localparam int FRAME_DATA_BITS = 16;
   typedef logic [$clog2(FRAME_BITS)-1:0] frame_cnt_t;
   // down counter values, sampled before the edge they act on
   localparam frame_cnt_t FRAME_CNT_LOAD  = frame_cnt_t'(FRAME_BITS - 1);
   localparam frame_cnt_t FRAME_CNT_ADDR  = frame_cnt_t'(FRAME_BITS - 1 - FRAME_ADDR_BITS);
   localparam frame_cnt_t FRAME_CNT_WRITE = frame_cnt_t'(FRAME_BITS - 1 - FRAME_ADDR_BITS
                                                         - FRAME_DATA_BITS);
   // two cycles of bank latency before the read window opens
   localparam frame_cnt_t FRAME_CNT_MISO_OFF = frame_cnt_t'(FRAME_BITS - 3 - FRAME_ADDR_BITS
                                                            - FRAME_DATA_BITS);
   localparam frame_cnt_t FRAME_CNT_END   = frame_cnt_t'(1);

   // symbol output flow control
   localparam int QAM_CREDITS = 4;
   typedef logic [$clog2(QAM_CREDITS+1)-1:0] credit_t;

   typedef logic signed [3:0] qam_level_t;        // +-1 +-3 +-5 +-7

   typedef enum logic [2:0] {SPI_IDLE, SPI_RW, SPI_ADDR, SPI_READ, SPI_WRITE} spi_state_t;
   typedef enum logic [2:0] {MAP_POLL, MAP_FETCH, MAP_EMIT, MAP_STATUS, MAP_CLEAR} map_state_t;

endpackage

`default_nettype wire
